//--- pinmux_reg.f
+incdir+logic
logic/pinmux_pkg.sv
logic/pinmux_bus_decode.sv
logic/pinmux_cfg_regs.sv
logic/pinmux_gpio_intr.sv
logic/pinmux_read_result.sv
logic/pinmux_reg.sv
dv/pinmux_clk_gen.sv
dv/pinmux_reg_tb.sv

//--- Bender.yml
package:
  name: pinmux_reg

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/pinmux_pkg.sv
      - logic/pinmux_bus_decode.sv
      - logic/pinmux_cfg_regs.sv
      - logic/pinmux_gpio_intr.sv
      - logic/pinmux_read_result.sv
      - logic/pinmux_reg.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/pinmux_clk_gen.sv
      - dv/pinmux_reg_tb.sv

//--- dv/pinmux_reg_tb.sv
`timescale 1ns/100ps
`include "pinmux_config.svh"

module pinmux_reg_tb;

   logic        mclk, h_reset_n;
   logic        reg_cs, reg_wr, reg_ack;
   logic [7:0]  reg_addr;
   logic [31:0] reg_wdata, reg_rdata;
   logic [3:0]  reg_be;
   logic [1:0]  ext_intr_in;
   logic [31:0] gpio_in_data, gpio_int_event, fuse_mhartid, gpio_prev_indata;
   logic [31:0] cfg_gpio_out_data, cfg_gpio_data_in, cfg_gpio_dir_sel, cfg_gpio_out_type;
   logic [31:0] cfg_gpio_posedge_int_sel, cfg_gpio_negedge_int_sel;
   logic [15:0] irq_lines;
   logic        soft_irq;
   logic [2:0]  user_irq;
   logic [9:0]  cfg_pulse_1us;

   int          errors, checks, tests, test_err0;
   logic [31:0] lfsr = 32'h9fe9_1357;
   logic [31:0] exp_reg [0:31];   // Model of the plain config words
   logic [31:0] exp_status;       // Model of the interrupt status
   logic [31:0] in_d1, in_d2, in_d3;  // GPIO input history

   localparam int wr_idx_list [8] = '{`PINMUX_IDX_GPIO_OUT, `PINMUX_IDX_GPIO_DIR,
      `PINMUX_IDX_GPIO_TYPE, `PINMUX_IDX_POS_SEL, `PINMUX_IDX_NEG_SEL,
      `PINMUX_IDX_INT_MASK, `PINMUX_IDX_FUSE, `PINMUX_IDX_PULSE};
   localparam int dropped_idx [10] = '{8, 14, 15, 16, 17, 18, 19, 20, 21, 31};

   pinmux_clk_gen clk_gen_i (.mclk, .h_reset_n);
   pinmux_reg pinmux_reg_i (.*);

   // ----------------------------------------
   // Continuous checks
   // ----------------------------------------
   a_ack_single : assert property (@(posedge mclk) disable iff (!h_reset_n)
      reg_ack |=> !reg_ack)
   else
   begin
      $display("reg_ack stayed high for two cycles");
      errors++;
   end

   a_ext_irq : assert property (@(posedge mclk) disable iff (!h_reset_n)
      user_irq[1:0] == ext_intr_in)
   else
   begin
      $display("user_irq low bits do not follow ext_intr_in");
      errors++;
   end

   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         in_d1 <= '0;
         in_d2 <= '0;
         in_d3 <= '0;
      end
      else
      begin
         in_d1 <= gpio_in_data;
         in_d2 <= in_d1;
         in_d3 <= in_d2;
      end
   end

   // Synchronizer depth, checked away from the sampling edge
   always @(negedge mclk)
   begin
      if (h_reset_n)
      begin
         assert (gpio_prev_indata === in_d2)
         else
         begin
            $display("ERROR gpio_prev_indata got %h expected %h", gpio_prev_indata, in_d2);
            errors++;
         end
         assert (cfg_gpio_data_in === in_d3)
         else
         begin
            $display("ERROR cfg_gpio_data_in got %h expected %h", cfg_gpio_data_in, in_d3);
            errors++;
         end
      end
   end

   // ----------------------------------------
   // Helpers
   // ----------------------------------------
   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [31:0] lane_mask(input logic [3:0] bes);
      return {{8{bes[3]}}, {8{bes[2]}}, {8{bes[1]}}, {8{bes[0]}}};
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $finish;
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("ERROR %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      $display("test %-14s %s", name, (errors == test_err0) ? "ok" : "has errors");
      tests++;
      test_err0 = errors;
   endtask

   // One access, reg_cs held for extra cycles after the ack
   task automatic bus_access(input logic wr, input logic [4:0] idx, input logic [31:0] data,
                             input logic [3:0] bes, input int hold,
                             input logic [31:0] wr_ev, output logic [31:0] rdata);
      int cnt;
      cnt = 0;
      @(negedge mclk);
      reg_cs    = 1'b1;
      reg_wr    = wr;
      reg_addr  = {1'b0, idx, 2'b00};
      reg_wdata = data;
      reg_be    = bes;
      @(negedge mclk);
      gpio_int_event = wr_ev;   // One cycle, on the write strobe edge
      @(negedge mclk);
      gpio_int_event = '0;
      while (!reg_ack)
      begin
         cnt++;
         if (cnt > 8)
            abort_run("no reg_ack within 8 cycles of reg_cs");
         @(negedge mclk);
      end
      rdata = reg_rdata;
      for (int k = 0; k < hold; k++)
      begin
         @(negedge mclk);
         assert (!reg_ack)
         else
         begin
            $display("second reg_ack while reg_cs was held");
            errors++;
         end
      end
      reg_cs = 1'b0;
      repeat (2) @(negedge mclk);   // Bus idle gap
   endtask

   task automatic reg_write(input logic [4:0] idx, input logic [31:0] data,
                            input logic [3:0] bes);
      logic [31:0] unused;
      bus_access(1'b1, idx, data, bes, 0, '0, unused);
   endtask

   task automatic reg_read(input logic [4:0] idx, output logic [31:0] data);
      bus_access(1'b0, idx, '0, 4'h0, 0, '0, data);
   endtask

   task automatic check_status();
      logic [31:0] rd;
      reg_read(`PINMUX_IDX_INT_CLR, rd);
      check_val("reg_rdata[9]", rd, exp_status);
      reg_read(`PINMUX_IDX_INT_SET, rd);
      check_val("reg_rdata[10]", rd, exp_status);
   endtask

   task automatic check_cfg_out(input logic [4:0] idx, input logic [31:0] exp);
      case (idx)
         `PINMUX_IDX_FUSE      : check_val("fuse_mhartid", fuse_mhartid, exp);
         `PINMUX_IDX_GPIO_OUT  : check_val("cfg_gpio_out_data", cfg_gpio_out_data, exp);
         `PINMUX_IDX_GPIO_DIR  : check_val("cfg_gpio_dir_sel", cfg_gpio_dir_sel, exp);
         `PINMUX_IDX_GPIO_TYPE : check_val("cfg_gpio_out_type", cfg_gpio_out_type, exp);
         `PINMUX_IDX_POS_SEL   :
            check_val("cfg_gpio_posedge_int_sel", cfg_gpio_posedge_int_sel, exp);
         `PINMUX_IDX_NEG_SEL   :
            check_val("cfg_gpio_negedge_int_sel", cfg_gpio_negedge_int_sel, exp);
         `PINMUX_IDX_PULSE     : check_val("cfg_pulse_1us", {22'b0, cfg_pulse_1us}, exp);
         default               : ;  // Mask is not a port
      endcase
   endtask

   // ----------------------------------------
   // Stimulus
   // ----------------------------------------
   initial
   begin
      logic [31:0] rd, data, ev, lm, mask, exp_irq;
      logic [3:0]  bes;
      logic [1:0]  ext;
      int          cnt;
      {reg_cs, reg_wr, reg_addr, reg_wdata, reg_be} = '0;
      {ext_intr_in, gpio_in_data, gpio_int_event} = '0;
      {errors, checks, tests, test_err0, cnt} = '0;
      exp_status = '0;
      exp_irq    = '0;
      for (int i = 0; i < 32; i++)
         exp_reg[i] = '0;
      exp_reg[`PINMUX_IDX_FUSE] = `PINMUX_FUSE_RST;
      while (h_reset_n !== 1'b1)
      begin
         cnt++;
         if (cnt > 20)
            abort_run("h_reset_n never released");
         @(negedge mclk);
      end

      // Reset values
      check_val("reg_ack", reg_ack, 0);
      check_val("reg_rdata", reg_rdata, 0);
      for (int i = 0; i < 8; i++)
         check_cfg_out(wr_idx_list[i], exp_reg[wr_idx_list[i]]);
      check_val("irq_lines", irq_lines, 0);
      check_val("soft_irq", soft_irq, 0);
      check_val("user_irq", user_irq, 0);
      reg_read(`PINMUX_IDX_CHIP_ID, rd);
      check_val("reg_rdata[0]", rd, 32'h8949_0201);
      reg_read(`PINMUX_IDX_FUSE, rd);
      check_val("reg_rdata[1]", rd, 32'hA55A_A55A);
      end_test("reset_values");

      // Byte-lane writes against the lane model
      for (int r = 0; r < 3; r++)
      begin
         for (int i = 0; i < 8; i++)
         begin
            data = rand_bits(32);
            bes  = rand_bits(4);
            lm   = lane_mask(bes);
            reg_write(wr_idx_list[i], data, bes);
            exp_reg[wr_idx_list[i]] = (exp_reg[wr_idx_list[i]] & ~lm) | (data & lm);
            if (wr_idx_list[i] == `PINMUX_IDX_PULSE)
               exp_reg[wr_idx_list[i]] &= 32'h0000_03FF;  // 10-bit divider
            reg_read(wr_idx_list[i], rd);
            check_val("reg_rdata", rd, exp_reg[wr_idx_list[i]]);
            check_cfg_out(wr_idx_list[i], exp_reg[wr_idx_list[i]]);
         end
      end
      end_test("byte_writes");

      // GPIO capture path
      for (int r = 0; r < 4; r++)
      begin
         @(negedge mclk);
         data         = rand_bits(32);
         gpio_in_data = data;
         repeat (3) @(negedge mclk);
         reg_read(`PINMUX_IDX_GPIO_IN, rd);
         check_val("reg_rdata[2]", rd, data);
      end
      end_test("gpio_input");

      // Interrupt status, events then W1S and W1C per lane
      ev = rand_bits(32);
      @(negedge mclk);
      gpio_int_event = ev;
      @(negedge mclk);
      gpio_int_event = '0;
      exp_status |= ev;
      check_status();
      for (int r = 0; r < 3; r++)
      begin
         data = rand_bits(32);
         bes  = rand_bits(4);
         reg_write(`PINMUX_IDX_INT_SET, data, bes);
         exp_status |= data & lane_mask(bes);
         check_status();
         data = rand_bits(32);
         bes  = rand_bits(4);
         reg_write(`PINMUX_IDX_INT_CLR, data, bes);
         exp_status &= ~(data & lane_mask(bes));
         check_status();
      end
      // Event pulse on the same edge as a full clear
      ev = rand_bits(32);
      bus_access(1'b1, `PINMUX_IDX_INT_CLR, 32'hFFFF_FFFF, 4'hF, 0, ev, rd);
      exp_status = ev;
      check_status();
      end_test("int_status");

      // RISC interrupt word and user IRQ vector
      for (int r = 0; r < 4; r++)
      begin
         data = rand_bits(32);
         bes  = rand_bits(4);
         lm   = lane_mask(bes);
         reg_write(`PINMUX_IDX_IRQ_CFG, data, bes);
         exp_irq[15:0] = (exp_irq[15:0] & ~lm[15:0]) | (data[15:0] & lm[15:0]);
         if (bes[2])
            exp_irq[16] = data[16];  // Lane 2 holds only the soft IRQ
         check_val("irq_lines", irq_lines, exp_irq[15:0]);
         check_val("soft_irq", soft_irq, exp_irq[16]);
         reg_read(`PINMUX_IDX_IRQ_CFG, rd);
         check_val("reg_rdata[6]", rd, exp_irq);
      end
      for (int r = 0; r < 4; r++)
      begin
         mask = (r == 0) ? '0 : rand_bits(32);
         reg_write(`PINMUX_IDX_INT_MASK, mask, 4'hF);
         data = rand_bits(32);
         reg_write(`PINMUX_IDX_INT_SET, data, 4'hF);
         exp_status |= data;
         ext = rand_bits(2);
         ext_intr_in = ext;
         @(negedge mclk);
         check_val("user_irq", user_irq, {|(exp_status & mask), ext});
      end
      end_test("irq_outputs");

      // Held chip select, then unmapped reads
      reg_write(`PINMUX_IDX_INT_SET, 32'hFFFF_FFFF, 4'hF);
      data = rand_bits(32);
      ev   = data & rand_bits(32);   // A second clear during the hold would drop these
      bus_access(1'b1, `PINMUX_IDX_INT_CLR, data, 4'hF, 6, ev, rd);
      exp_status = ~data | ev;
      check_status();
      bus_access(1'b0, `PINMUX_IDX_CHIP_ID, '0, 4'h0, 4, '0, rd);
      check_val("reg_rdata[0]", rd, 32'h8949_0201);
      for (int i = 0; i < 10; i++)
      begin
         reg_read(dropped_idx[i], rd);
         check_val("reg_rdata", rd, 0);
      end
      end_test("protocol");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

//--- dv/pinmux_clk_gen.sv
`timescale 1ns/100ps

module pinmux_clk_gen (
   output logic mclk,
   output logic h_reset_n
);

   // 100 MHz clock
   initial
   begin
      mclk = 1'b0;
      forever #5 mclk = ~mclk;
   end

   // Reset held for 10 cycles, released on a falling edge
   initial
   begin
      h_reset_n = 1'b0;
      repeat (10) @(posedge mclk);
      @(negedge mclk);
      h_reset_n = 1'b1;
   end

endmodule

//--- logic/pinmux_reg.sv
`timescale 1ns/100ps
`include "pinmux_config.svh"

module pinmux_reg
   import pinmux_pkg::*;
(
   input  logic                        mclk,
   input  logic                        h_reset_n,

   // Register bus
   input  logic                        reg_cs,
   input  logic                        reg_wr,
   input  logic [`PINMUX_AW-1:0]       reg_addr,
   input  logic [`PINMUX_DW-1:0]       reg_wdata,
   input  logic [`PINMUX_BEW-1:0]      reg_be,
   output logic [`PINMUX_DW-1:0]       reg_rdata,
   output logic                        reg_ack,

   input  logic [`PINMUX_EXT_IRQS-1:0] ext_intr_in,
   input  logic [`PINMUX_DW-1:0]       gpio_in_data,
   input  logic [`PINMUX_DW-1:0]       gpio_int_event,

   // RISC configuration
   output logic [`PINMUX_DW-1:0]       fuse_mhartid,
   output logic [`PINMUX_IRQ_LINES-1:0] irq_lines,
   output logic                        soft_irq,
   output logic [`PINMUX_EXT_IRQS:0]   user_irq,
   output logic [`PINMUX_PULSE_W-1:0]  cfg_pulse_1us,

   // GPIO configuration
   output logic [`PINMUX_DW-1:0]       cfg_gpio_out_data,
   output logic [`PINMUX_DW-1:0]       cfg_gpio_data_in,
   output logic [`PINMUX_DW-1:0]       cfg_gpio_dir_sel,
   output logic [`PINMUX_DW-1:0]       cfg_gpio_out_type,
   output logic [`PINMUX_DW-1:0]       cfg_gpio_posedge_int_sel,
   output logic [`PINMUX_DW-1:0]       cfg_gpio_negedge_int_sel,
   output logic [`PINMUX_DW-1:0]       gpio_prev_indata
);

   // ----------------------------------------
   // Stage interconnect
   // ----------------------------------------
   logic                    acc_start;
   logic                    acc_rd;
   logic                    wr_stb;
   logic [`PINMUX_IDXW-1:0] reg_idx;
   logic [`PINMUX_DW-1:0]   wdata;
   logic [`PINMUX_BEW-1:0]  be;
   logic [`PINMUX_DW-1:0]   int_mask;
   logic [`PINMUX_DW-1:0]   int_status;
   irq_cfg_u                irq_cfg;
   logic                    gpio_intr;

   // Bus capture
   pinmux_bus_decode u_decode (
      .mclk, .h_reset_n, .reg_cs, .reg_wr, .reg_addr, .reg_wdata, .reg_be,
      .acc_start, .acc_rd, .wr_stb, .reg_idx, .wdata, .be
   );

   // Configuration words
   pinmux_cfg_regs u_cfg_regs (
      .mclk, .h_reset_n, .wr_stb, .reg_idx, .wdata, .be,
      .fuse_mhartid, .cfg_gpio_out_data, .cfg_gpio_dir_sel, .cfg_gpio_out_type,
      .cfg_gpio_posedge_int_sel, .cfg_gpio_negedge_int_sel, .int_mask,
      .irq_cfg, .irq_lines, .soft_irq, .cfg_pulse_1us
   );

   // GPIO capture and interrupt status
   pinmux_gpio_intr u_gpio_intr (
      .mclk, .h_reset_n, .gpio_in_data, .gpio_int_event,
      .wr_stb, .reg_idx, .wdata, .be, .int_mask,
      .cfg_gpio_data_in, .gpio_prev_indata, .int_status, .gpio_intr
   );

   // Read data and acknowledge
   pinmux_read_result u_result (
      .mclk, .h_reset_n, .acc_start, .acc_rd, .reg_idx,
      .fuse_mhartid, .cfg_gpio_data_in, .cfg_gpio_out_data, .cfg_gpio_dir_sel,
      .cfg_gpio_out_type, .irq_cfg, .cfg_pulse_1us, .int_status, .int_mask,
      .cfg_gpio_posedge_int_sel, .cfg_gpio_negedge_int_sel,
      .reg_rdata, .reg_ack
   );

   assign user_irq = {gpio_intr, ext_intr_in};  // GPIO on top bit

endmodule

//--- logic/pinmux_read_result.sv
`timescale 1ns/100ps
`include "pinmux_config.svh"

module pinmux_read_result
   import pinmux_pkg::*;
(
   input  logic                       mclk,
   input  logic                       h_reset_n,

   input  logic                       acc_start,
   input  logic                       acc_rd,
   input  logic [`PINMUX_IDXW-1:0]    reg_idx,

   // Readable words
   input  logic [`PINMUX_DW-1:0]      fuse_mhartid,
   input  logic [`PINMUX_DW-1:0]      cfg_gpio_data_in,
   input  logic [`PINMUX_DW-1:0]      cfg_gpio_out_data,
   input  logic [`PINMUX_DW-1:0]      cfg_gpio_dir_sel,
   input  logic [`PINMUX_DW-1:0]      cfg_gpio_out_type,
   input  irq_cfg_u                   irq_cfg,
   input  logic [`PINMUX_PULSE_W-1:0] cfg_pulse_1us,
   input  logic [`PINMUX_DW-1:0]      int_status,
   input  logic [`PINMUX_DW-1:0]      int_mask,
   input  logic [`PINMUX_DW-1:0]      cfg_gpio_posedge_int_sel,
   input  logic [`PINMUX_DW-1:0]      cfg_gpio_negedge_int_sel,

   output logic [`PINMUX_DW-1:0]      reg_rdata,
   output logic                       reg_ack
);

   logic [`PINMUX_DW-1:0] rd_mux;

   // ----------------------------------------
   // Read multiplexer
   // ----------------------------------------
   always_comb
   begin
      case (reg_idx)
         `PINMUX_IDX_CHIP_ID   : rd_mux = {`PINMUX_MANU_ID, `PINMUX_CHIP_ID, `PINMUX_CHIP_REV};
         `PINMUX_IDX_FUSE      : rd_mux = fuse_mhartid;
         `PINMUX_IDX_GPIO_IN   : rd_mux = cfg_gpio_data_in;
         `PINMUX_IDX_GPIO_OUT  : rd_mux = cfg_gpio_out_data;
         `PINMUX_IDX_GPIO_DIR  : rd_mux = cfg_gpio_dir_sel;
         `PINMUX_IDX_GPIO_TYPE : rd_mux = cfg_gpio_out_type;
         `PINMUX_IDX_IRQ_CFG   : rd_mux = irq_cfg.raw;
         `PINMUX_IDX_PULSE     :
            rd_mux = {{(`PINMUX_DW-`PINMUX_PULSE_W){1'b0}}, cfg_pulse_1us};
         `PINMUX_IDX_INT_CLR,
         `PINMUX_IDX_INT_SET   : rd_mux = int_status;   // Both views same word
         `PINMUX_IDX_INT_MASK  : rd_mux = int_mask;
         `PINMUX_IDX_POS_SEL   : rd_mux = cfg_gpio_posedge_int_sel;
         `PINMUX_IDX_NEG_SEL   : rd_mux = cfg_gpio_negedge_int_sel;
         default               : rd_mux = '0;            // Dropped or unmapped
      endcase
   end

   // Data held until the next read
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         reg_rdata <= '0;
         reg_ack   <= 1'b0;
      end
      else
      begin
         reg_ack <= acc_start;   // One pulse per access
         if (acc_start && acc_rd)
            reg_rdata <= rd_mux;
      end
   end

   a_ack_pulse : assert property (@(posedge mclk) disable iff (!h_reset_n)
      reg_ack |=> !reg_ack);

endmodule

//--- logic/pinmux_gpio_intr.sv
`timescale 1ns/100ps
`include "pinmux_config.svh"

module pinmux_gpio_intr (
   input  logic                    mclk,
   input  logic                    h_reset_n,

   // GPIO side
   input  logic [`PINMUX_DW-1:0]   gpio_in_data,    // Asynchronous pins
   input  logic [`PINMUX_DW-1:0]   gpio_int_event,  // From GPIO control block

   // Decoded write
   input  logic                    wr_stb,
   input  logic [`PINMUX_IDXW-1:0] reg_idx,
   input  logic [`PINMUX_DW-1:0]   wdata,
   input  logic [`PINMUX_BEW-1:0]  be,

   input  logic [`PINMUX_DW-1:0]   int_mask,

   output logic [`PINMUX_DW-1:0]   cfg_gpio_data_in,
   output logic [`PINMUX_DW-1:0]   gpio_prev_indata,
   output logic [`PINMUX_DW-1:0]   int_status,
   output logic                    gpio_intr
);

   logic [`PINMUX_DW-1:0] gpio_in_s;    // First sync flop
   logic [`PINMUX_DW-1:0] status_nxt;
   logic                  clr_wr;       // W1C access
   logic                  set_wr;       // W1S access

   // ----------------------------------------
   // Input synchronizer and capture
   // ----------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         gpio_in_s        <= '0;
         gpio_prev_indata <= '0;
         cfg_gpio_data_in <= '0;
      end
      else
      begin
         gpio_in_s        <= gpio_in_data;
         gpio_prev_indata <= gpio_in_s;         // Safe after 2 edges
         cfg_gpio_data_in <= gpio_prev_indata;  // One sample older
      end
   end

   // ----------------------------------------
   // Interrupt status
   // ----------------------------------------
   assign clr_wr = wr_stb && (reg_idx == `PINMUX_IDX_INT_CLR);
   assign set_wr = wr_stb && (reg_idx == `PINMUX_IDX_INT_SET);

   always_comb
   begin
      status_nxt = int_status;
      for (int i = 0; i < `PINMUX_BEW; i++)
      begin
         if (clr_wr && be[i])
            status_nxt[8*i +: 8] = int_status[8*i +: 8] & ~wdata[8*i +: 8];
         else if (set_wr && be[i])
            status_nxt[8*i +: 8] = int_status[8*i +: 8] | wdata[8*i +: 8];
      end
      // Hardware event beats a host clear
      status_nxt = status_nxt | gpio_int_event;
   end

   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
         int_status <= '0;
      else
         int_status <= status_nxt;   // Updated every cycle
   end

   assign gpio_intr = |(int_status & int_mask);  // To RISC user IRQ

   a_event_sets : assert property (@(posedge mclk) disable iff (!h_reset_n)
      (gpio_int_event != '0) |=>
         ((int_status & $past(gpio_int_event)) == $past(gpio_int_event)));

endmodule

//--- logic/pinmux_cfg_regs.sv
`timescale 1ns/100ps
`include "pinmux_config.svh"

module pinmux_cfg_regs
   import pinmux_pkg::*;
(
   input  logic                        mclk,
   input  logic                        h_reset_n,

   // Decoded write
   input  logic                        wr_stb,
   input  logic [`PINMUX_IDXW-1:0]     reg_idx,
   input  logic [`PINMUX_DW-1:0]       wdata,
   input  logic [`PINMUX_BEW-1:0]      be,

   // Configuration words
   output logic [`PINMUX_DW-1:0]       fuse_mhartid,
   output logic [`PINMUX_DW-1:0]       cfg_gpio_out_data,
   output logic [`PINMUX_DW-1:0]       cfg_gpio_dir_sel,
   output logic [`PINMUX_DW-1:0]       cfg_gpio_out_type,
   output logic [`PINMUX_DW-1:0]       cfg_gpio_posedge_int_sel,
   output logic [`PINMUX_DW-1:0]       cfg_gpio_negedge_int_sel,
   output logic [`PINMUX_DW-1:0]       int_mask,

   // RISC interrupt word and its fields
   output irq_cfg_u                    irq_cfg,
   output logic [`PINMUX_IRQ_LINES-1:0] irq_lines,
   output logic                        soft_irq,

   output logic [`PINMUX_PULSE_W-1:0]  cfg_pulse_1us
);

   // ----------------------------------------
   // Byte-lane writes
   // ----------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         fuse_mhartid             <= `PINMUX_FUSE_RST;  // Non-zero hart ID
         cfg_gpio_out_data        <= '0;
         cfg_gpio_dir_sel         <= '0;
         cfg_gpio_out_type        <= '0;
         cfg_gpio_posedge_int_sel <= '0;
         cfg_gpio_negedge_int_sel <= '0;
         int_mask                 <= '0;
         irq_cfg.raw              <= '0;
         cfg_pulse_1us            <= '0;
      end
      else if (wr_stb)
      begin
         for (int i = 0; i < `PINMUX_BEW; i++)
         begin
            if (be[i])
            begin
               case (reg_idx)
                  `PINMUX_IDX_FUSE      : fuse_mhartid[8*i +: 8]      <= wdata[8*i +: 8];
                  `PINMUX_IDX_GPIO_OUT  : cfg_gpio_out_data[8*i +: 8] <= wdata[8*i +: 8];
                  `PINMUX_IDX_GPIO_DIR  : cfg_gpio_dir_sel[8*i +: 8]  <= wdata[8*i +: 8];
                  `PINMUX_IDX_GPIO_TYPE : cfg_gpio_out_type[8*i +: 8] <= wdata[8*i +: 8];
                  `PINMUX_IDX_INT_MASK  : int_mask[8*i +: 8]          <= wdata[8*i +: 8];
                  `PINMUX_IDX_POS_SEL   :
                     cfg_gpio_posedge_int_sel[8*i +: 8] <= wdata[8*i +: 8];
                  `PINMUX_IDX_NEG_SEL   :
                     cfg_gpio_negedge_int_sel[8*i +: 8] <= wdata[8*i +: 8];
                  `PINMUX_IDX_IRQ_CFG   :
                  begin
                     // IRQ lines on lanes 0-1, soft IRQ alone on lane 2
                     if (i < 2)
                        irq_cfg.raw[8*i +: 8] <= wdata[8*i +: 8];
                     else if (i == 2)
                        irq_cfg.f.soft_irq <= wdata[`PINMUX_IRQ_LINES];
                  end
                  `PINMUX_IDX_PULSE     :
                  begin
                     // Only 10 bits exist, lane 1 carries the top two
                     if (i == 0)
                        cfg_pulse_1us[7:0] <= wdata[7:0];
                     else if (i == 1)
                        cfg_pulse_1us[`PINMUX_PULSE_W-1:8] <= wdata[`PINMUX_PULSE_W-1:8];
                  end
                  default : ;  // Read-only or unmapped
               endcase
            end
         end
      end
   end

   // Field view to the RISC core
   assign irq_lines = irq_cfg.f.irq_lines;
   assign soft_irq  = irq_cfg.f.soft_irq;   // Lane 2 bit 0

   a_rsvd_zero : assert property (@(posedge mclk) disable iff (!h_reset_n)
      irq_cfg.f.rsvd == '0);

endmodule

//--- logic/pinmux_bus_decode.sv
`timescale 1ns/100ps
`include "pinmux_config.svh"

module pinmux_bus_decode (
   input  logic                    mclk,
   input  logic                    h_reset_n,

   // Register bus from host
   input  logic                    reg_cs,
   input  logic                    reg_wr,
   input  logic [`PINMUX_AW-1:0]   reg_addr,
   input  logic [`PINMUX_DW-1:0]   reg_wdata,
   input  logic [`PINMUX_BEW-1:0]  reg_be,

   // Decoded access, one cycle each
   output logic                    acc_start,
   output logic                    acc_rd,
   output logic                    wr_stb,
   output logic [`PINMUX_IDXW-1:0] reg_idx,
   output logic [`PINMUX_DW-1:0]   wdata,
   output logic [`PINMUX_BEW-1:0]  be
);

   logic cs_d;     // Chip select, last sample
   logic cs_rise;  // First cycle of an access

   // Held chip select gives no second start
   assign cs_rise = reg_cs & ~cs_d;

   // ----------------------------------------
   // Access strobes
   // ----------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         cs_d      <= 1'b0;
         acc_start <= 1'b0;
         acc_rd    <= 1'b0;
         wr_stb    <= 1'b0;
      end
      else
      begin
         cs_d      <= reg_cs;
         acc_start <= cs_rise;
         acc_rd    <= cs_rise & ~reg_wr;  // Read start
         wr_stb    <= cs_rise & reg_wr;   // Write start
      end
   end

   // Captured with the start, payload only
   always_ff @(posedge mclk)
   begin
      if (cs_rise)
      begin
         reg_idx <= reg_addr[`PINMUX_IDX_MSB:`PINMUX_IDX_LSB];  // Word index
         wdata   <= reg_wdata;
         be      <= reg_be;
      end
   end

   // Every start is exactly one of read or write
   a_one_kind : assert property (@(posedge mclk) disable iff (!h_reset_n)
      !(acc_rd && wr_stb) && (acc_start == (acc_rd || wr_stb)));

endmodule

//--- logic/pinmux_pkg.sv
`include "pinmux_config.svh"

package pinmux_pkg;

   // ----------------------------------------
   // RISC interrupt configuration word
   // ----------------------------------------

   // Field view, MSB first
   typedef struct packed
   {
      logic [`PINMUX_DW-`PINMUX_IRQ_LINES-2:0] rsvd;      // Always zero
      logic                                    soft_irq;  // Lane 2, bit 0
      logic [`PINMUX_IRQ_LINES-1:0]            irq_lines; // Lanes 0 and 1
   } irq_cfg_t;

   // Bus writes raw lanes, consumers read the fields
   typedef union packed
   {
      logic [`PINMUX_DW-1:0] raw;
      irq_cfg_t              f;
   } irq_cfg_u;

endpackage

//--- logic/pinmux_config.svh
`ifndef PINMUX_CONFIG_SVH
`define PINMUX_CONFIG_SVH

// ----------------------------------------
// Bus geometry
// ----------------------------------------
`define PINMUX_DW        32          // Register and bus word
`define PINMUX_BEW       4           // One enable per byte lane
`define PINMUX_AW        8           // Byte address
`define PINMUX_IDX_LSB   2
`define PINMUX_IDX_MSB   6
`define PINMUX_IDXW      5

// ----------------------------------------
// Register map, word indices
// ----------------------------------------
`define PINMUX_IDX_CHIP_ID    5'd0
`define PINMUX_IDX_FUSE       5'd1
`define PINMUX_IDX_GPIO_IN    5'd2
`define PINMUX_IDX_GPIO_OUT   5'd3
`define PINMUX_IDX_GPIO_DIR   5'd4
`define PINMUX_IDX_GPIO_TYPE  5'd5
`define PINMUX_IDX_IRQ_CFG    5'd6
`define PINMUX_IDX_PULSE      5'd7
`define PINMUX_IDX_INT_CLR    5'd9    // W1C view of status
`define PINMUX_IDX_INT_SET    5'd10   // W1S view of status
`define PINMUX_IDX_INT_MASK   5'd11
`define PINMUX_IDX_POS_SEL    5'd12
`define PINMUX_IDX_NEG_SEL    5'd13

// Identification and reset values
`define PINMUX_MANU_ID    16'h8949
`define PINMUX_CHIP_ID    8'h02
`define PINMUX_CHIP_REV   8'h01
`define PINMUX_FUSE_RST   32'hA55A_A55A

`define PINMUX_PULSE_W    10
`define PINMUX_IRQ_LINES  16
`define PINMUX_EXT_IRQS   2

`endif
